//--- Bender.yml
package:
  name: l1_dcache

export_include_dirs:
  - src

sources:
  - files:
      - src/l1_cache_pkg.sv
      - src/l2_credit_counter.sv
      - src/tag_mesi_array.sv
      - src/data_array.sv
      - src/l1_cache_ctrl_fsm.sv
      - src/l1_dcache.sv
  - target: test
    files:
      - verification/tb_l1_dcache.sv

//--- src.f
+incdir+src
src/l1_cache_pkg.sv
src/l2_credit_counter.sv
src/tag_mesi_array.sv
src/data_array.sv
src/l1_cache_ctrl_fsm.sv
src/l1_dcache.sv
verification/tb_l1_dcache.sv

//--- src/data_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_cache_settings.svh"

module data_array (
    input  wire                          clk,
    input  wire l1_cache_pkg::index_t    lookup_index,
    input  wire l1_cache_pkg::way_t      rd_way,
    input  wire                          data_we,
    input  wire l1_cache_pkg::way_t      data_way,
    input  wire l1_cache_pkg::data_t     data_wdata,
    output l1_cache_pkg::data_t          rd_data
);

    localparam int SETS = 1 << `L1_INDEX_WID;

    // one word per line
    l1_cache_pkg::data_t mem [SETS][`L1_WAYS];

    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[lookup_index][data_way] <= data_wdata;
        end
    end

    // registered read, returns the word before a same-cycle write
    always_ff @(posedge clk) begin
        rd_data <= mem[lookup_index][rd_way];
    end

endmodule

`default_nettype wire

//--- src/l1_cache_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_cache_settings.svh"

module l1_cache_ctrl_fsm (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          cpu_req_valid,
    input  wire                          cpu_req_write,
    input  wire l1_cache_pkg::addr_t     cpu_req_addr,
    input  wire l1_cache_pkg::data_t     cpu_req_wdata,
    input  wire                          l2_rsp_valid,
    input  wire l1_cache_pkg::data_t     l2_rsp_data,
    input  wire                          l2_rsp_shared,
    input  wire                          has_credit,
    input  wire                          hit,
    input  wire l1_cache_pkg::way_t      hit_way,
    input  wire l1_cache_pkg::mesi_t     hit_state,
    input  wire l1_cache_pkg::way_t      victim_way,
    input  wire l1_cache_pkg::tag_t      victim_tag,
    input  wire l1_cache_pkg::mesi_t     victim_state,
    input  wire l1_cache_pkg::data_t     rd_data,
    output logic                         cpu_req_ready,
    output logic                         cpu_rsp_valid,
    output l1_cache_pkg::data_t          cpu_rsp_rdata,
    output logic                         l2_req_valid,
    output l1_cache_pkg::l2_op_t         l2_req_op,
    output l1_cache_pkg::addr_t          l2_req_addr,
    output l1_cache_pkg::data_t          l2_req_wdata,
    output logic                         consume,
    output l1_cache_pkg::index_t         lookup_index,
    output logic                         tag_we,
    output l1_cache_pkg::way_t           tag_way,
    output l1_cache_pkg::tag_t           tag_new_tag,
    output l1_cache_pkg::mesi_t          tag_new_state,
    output logic                         tag_fill,
    output logic                         data_we,
    output l1_cache_pkg::way_t           data_way,
    output l1_cache_pkg::data_t          data_wdata
);

    localparam int TAG_LSB = `L1_OFFSET_WID + `L1_INDEX_WID;

    l1_cache_pkg::ctrl_state_t  state;
    l1_cache_pkg::ctrl_state_t  state_next;

    // request in service
    l1_cache_pkg::tag_t    tag_q;
    l1_cache_pkg::index_t  index_q;
    logic                  write_q;
    l1_cache_pkg::data_t   wdata_q;

    l1_cache_pkg::way_t    way_q;
    l1_cache_pkg::tag_t    victim_tag_q;
    l1_cache_pkg::way_t    sel_way;
    l1_cache_pkg::mesi_t   fill_state;
    logic                  send_state;

    // ==============================
    // state and request registers
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= l1_cache_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            tag_q   <= cpu_req_addr[`L1_ADDR_WID-1:TAG_LSB];
            index_q <= cpu_req_addr[TAG_LSB-1:`L1_OFFSET_WID];
            write_q <= cpu_req_write;
            wdata_q <= cpu_req_wdata;
        end
        // way and victim tag held for write-back, fill and upgrade
        if (state == l1_cache_pkg::ST_LOOKUP) begin
            way_q        <= sel_way;
            victim_tag_q <= victim_tag;
        end
    end

    assign sel_way    = hit ? hit_way : victim_way;
    assign fill_state = (!write_q && l2_rsp_shared) ? l1_cache_pkg::SHARED
                                                    : l1_cache_pkg::EXCLUSIVE;

    // ==============================
    // next state and array commands
    // ==============================
    always_comb begin
        state_next    = state;
        tag_we        = 1'b0;
        tag_new_state = l1_cache_pkg::MODIFIED;
        tag_fill      = 1'b0;
        data_we       = 1'b0;
        data_wdata    = wdata_q;
        case (state)
            l1_cache_pkg::ST_IDLE: begin
                if (cpu_req_valid) begin
                    state_next = l1_cache_pkg::ST_LOOKUP;
                end
            end
            l1_cache_pkg::ST_LOOKUP: begin
                if (hit && !write_q) begin
                    state_next = l1_cache_pkg::ST_RESPOND;
                end else if (hit && hit_state == l1_cache_pkg::SHARED) begin
                    state_next = l1_cache_pkg::ST_UPGR_SEND;
                end else if (hit) begin
                    // exclusive or modified, finish locally
                    tag_we     = 1'b1;
                    data_we    = 1'b1;
                    state_next = l1_cache_pkg::ST_RESPOND;
                end else if (victim_state == l1_cache_pkg::MODIFIED) begin
                    state_next = l1_cache_pkg::ST_WB_SEND;
                end else begin
                    state_next = l1_cache_pkg::ST_FILL_SEND;
                end
            end
            l1_cache_pkg::ST_WB_SEND: begin
                if (has_credit) begin
                    state_next = l1_cache_pkg::ST_FILL_SEND;
                end
            end
            l1_cache_pkg::ST_FILL_SEND: begin
                if (has_credit) begin
                    state_next = l1_cache_pkg::ST_FILL_WAIT;
                end
            end
            l1_cache_pkg::ST_FILL_WAIT: begin
                // fill, then look up again so the request completes as a hit
                if (l2_rsp_valid) begin
                    tag_we        = 1'b1;
                    tag_fill      = 1'b1;
                    tag_new_state = fill_state;
                    data_we       = 1'b1;
                    data_wdata    = l2_rsp_data;
                    state_next    = l1_cache_pkg::ST_LOOKUP;
                end
            end
            l1_cache_pkg::ST_UPGR_SEND: begin
                if (has_credit) begin
                    state_next = l1_cache_pkg::ST_UPGR_WAIT;
                end
            end
            l1_cache_pkg::ST_UPGR_WAIT: begin
                if (l2_rsp_valid) begin
                    tag_we     = 1'b1;
                    data_we    = 1'b1;
                    state_next = l1_cache_pkg::ST_RESPOND;
                end
            end
            l1_cache_pkg::ST_RESPOND: begin
                state_next = l1_cache_pkg::ST_IDLE;
            end
            default: begin
                state_next = l1_cache_pkg::ST_IDLE;
            end
        endcase
    end

    assign lookup_index = index_q;
    assign tag_new_tag  = tag_q;
    assign tag_way      = (state == l1_cache_pkg::ST_LOOKUP) ? sel_way : way_q;
    assign data_way     = tag_way;

    // ==============================
    // cpu and level 2 outputs
    // ==============================
    assign cpu_req_ready = (state == l1_cache_pkg::ST_IDLE);
    assign cpu_rsp_valid = (state == l1_cache_pkg::ST_RESPOND);
    assign cpu_rsp_rdata = rd_data;

    assign send_state = (state == l1_cache_pkg::ST_WB_SEND)   ||
                        (state == l1_cache_pkg::ST_FILL_SEND) ||
                        (state == l1_cache_pkg::ST_UPGR_SEND);

    // one request per cycle, only with a free credit
    assign l2_req_valid = send_state && has_credit;
    assign consume      = l2_req_valid;

    always_comb begin
        case (state)
            l1_cache_pkg::ST_WB_SEND:   l2_req_op = l1_cache_pkg::L2_WB;
            l1_cache_pkg::ST_UPGR_SEND: l2_req_op = l1_cache_pkg::L2_UPGR;
            default: begin
                l2_req_op = write_q ? l1_cache_pkg::L2_RDX : l1_cache_pkg::L2_RD;
            end
        endcase
    end

    assign l2_req_addr = (state == l1_cache_pkg::ST_WB_SEND)
                       ? {victim_tag_q, index_q, {`L1_OFFSET_WID{1'b0}}}
                       : {tag_q, index_q, {`L1_OFFSET_WID{1'b0}}};

    // victim word stays on the read port through the write-back
    assign l2_req_wdata = rd_data;

endmodule

`default_nettype wire

//--- src/l1_cache_pkg.sv
`default_nettype none

`include "l1_cache_settings.svh"

package l1_cache_pkg;

    typedef logic [`L1_ADDR_WID-1:0]       addr_t;
    typedef logic [`L1_DATA_WID-1:0]       data_t;
    typedef logic [`L1_TAG_WID-1:0]        tag_t;
    typedef logic [`L1_INDEX_WID-1:0]      index_t;
    typedef logic [$clog2(`L1_WAYS)-1:0]   way_t;

    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } mesi_t;

    // level 2 request opcodes
    typedef enum logic [1:0] {
        L2_RD   = 2'b00,
        L2_RDX  = 2'b01,
        L2_UPGR = 2'b10,
        L2_WB   = 2'b11
    } l2_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_SEND,
        ST_FILL_SEND,
        ST_FILL_WAIT,
        ST_UPGR_SEND,
        ST_UPGR_WAIT,
        ST_RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/l1_cache_settings.svh
`ifndef L1_CACHE_SETTINGS_SVH
`define L1_CACHE_SETTINGS_SVH

// ==============================
// address and data widths
// ==============================
`define L1_ADDR_WID    16
`define L1_DATA_WID    32

// byte offset stays zero on level 2 addresses
`define L1_OFFSET_WID  2
`define L1_INDEX_WID   4
`define L1_TAG_WID     10

// two-way only
`define L1_WAYS        2

// ==============================
// level 2 request credits
// ==============================
`define L2_CREDITS     2
`define L2_CREDIT_WID  2

`endif

//--- src/l1_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module l1_dcache (
    input  wire                          clk,
    input  wire                          reset,
    // cpu request and response
    input  wire                          cpu_req_valid,
    input  wire                          cpu_req_write,
    input  wire l1_cache_pkg::addr_t     cpu_req_addr,
    input  wire l1_cache_pkg::data_t     cpu_req_wdata,
    output logic                         cpu_req_ready,
    output logic                         cpu_rsp_valid,
    output l1_cache_pkg::data_t          cpu_rsp_rdata,
    // level 2 side
    input  wire                          l2_credit_return,
    input  wire                          l2_rsp_valid,
    input  wire l1_cache_pkg::data_t     l2_rsp_data,
    input  wire                          l2_rsp_shared,
    output logic                         l2_req_valid,
    output l1_cache_pkg::l2_op_t         l2_req_op,
    output l1_cache_pkg::addr_t          l2_req_addr,
    output l1_cache_pkg::data_t          l2_req_wdata
);

    logic                  has_credit;
    logic                  consume;

    l1_cache_pkg::index_t  lookup_index;
    logic                  hit;
    l1_cache_pkg::way_t    hit_way;
    l1_cache_pkg::mesi_t   hit_state;
    l1_cache_pkg::way_t    victim_way;
    l1_cache_pkg::tag_t    victim_tag;
    l1_cache_pkg::mesi_t   victim_state;

    logic                  tag_we;
    l1_cache_pkg::way_t    tag_way;
    l1_cache_pkg::tag_t    tag_new_tag;
    l1_cache_pkg::mesi_t   tag_new_state;
    logic                  tag_fill;

    logic                  data_we;
    l1_cache_pkg::way_t    data_way;
    l1_cache_pkg::data_t   data_wdata;
    l1_cache_pkg::data_t   rd_data;

    l1_cache_ctrl_fsm u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .cpu_req_valid    (cpu_req_valid),
        .cpu_req_write    (cpu_req_write),
        .cpu_req_addr     (cpu_req_addr),
        .cpu_req_wdata    (cpu_req_wdata),
        .l2_rsp_valid     (l2_rsp_valid),
        .l2_rsp_data      (l2_rsp_data),
        .l2_rsp_shared    (l2_rsp_shared),
        .has_credit       (has_credit),
        .hit              (hit),
        .hit_way          (hit_way),
        .hit_state        (hit_state),
        .victim_way       (victim_way),
        .victim_tag       (victim_tag),
        .victim_state     (victim_state),
        .rd_data          (rd_data),
        .cpu_req_ready    (cpu_req_ready),
        .cpu_rsp_valid    (cpu_rsp_valid),
        .cpu_rsp_rdata    (cpu_rsp_rdata),
        .l2_req_valid     (l2_req_valid),
        .l2_req_op        (l2_req_op),
        .l2_req_addr      (l2_req_addr),
        .l2_req_wdata     (l2_req_wdata),
        .consume          (consume),
        .lookup_index     (lookup_index),
        .tag_we           (tag_we),
        .tag_way          (tag_way),
        .tag_new_tag      (tag_new_tag),
        .tag_new_state    (tag_new_state),
        .tag_fill         (tag_fill),
        .data_we          (data_we),
        .data_way         (data_way),
        .data_wdata       (data_wdata)
    );

    l2_credit_counter u_credits (
        .clk              (clk),
        .reset            (reset),
        .consume          (consume),
        .l2_credit_return (l2_credit_return),
        .has_credit       (has_credit)
    );

    // the new tag is always the tag of the request in service
    tag_mesi_array u_tags (
        .clk              (clk),
        .reset            (reset),
        .lookup_index     (lookup_index),
        .lookup_tag       (tag_new_tag),
        .tag_we           (tag_we),
        .tag_way          (tag_way),
        .tag_new_tag      (tag_new_tag),
        .tag_new_state    (tag_new_state),
        .tag_fill         (tag_fill),
        .hit              (hit),
        .hit_way          (hit_way),
        .hit_state        (hit_state),
        .victim_way       (victim_way),
        .victim_tag       (victim_tag),
        .victim_state     (victim_state)
    );

    // read way follows the write way select
    data_array u_data (
        .clk              (clk),
        .lookup_index     (lookup_index),
        .rd_way           (data_way),
        .data_we          (data_we),
        .data_way         (data_way),
        .data_wdata       (data_wdata),
        .rd_data          (rd_data)
    );

endmodule

`default_nettype wire

//--- src/l2_credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_cache_settings.svh"

module l2_credit_counter (
    input  wire   clk,
    input  wire   reset,
    input  wire   consume,
    input  wire   l2_credit_return,
    output logic  has_credit
);

    // free level 2 request slots
    logic [`L2_CREDIT_WID-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= `L2_CREDIT_WID'(`L2_CREDITS);
        end else if (consume && !l2_credit_return) begin
            count <= count - 1'b1;
        end else if (l2_credit_return && !consume && count < `L2_CREDITS) begin
            count <= count + 1'b1;
        end
    end

    assign has_credit = (count != '0);

endmodule

`default_nettype wire

//--- src/tag_mesi_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_cache_settings.svh"

module tag_mesi_array (
    input  wire                          clk,
    input  wire                          reset,
    input  wire l1_cache_pkg::index_t    lookup_index,
    input  wire l1_cache_pkg::tag_t      lookup_tag,
    input  wire                          tag_we,
    input  wire l1_cache_pkg::way_t      tag_way,
    input  wire l1_cache_pkg::tag_t      tag_new_tag,
    input  wire l1_cache_pkg::mesi_t     tag_new_state,
    input  wire                          tag_fill,
    output logic                         hit,
    output l1_cache_pkg::way_t           hit_way,
    output l1_cache_pkg::mesi_t          hit_state,
    output l1_cache_pkg::way_t           victim_way,
    output l1_cache_pkg::tag_t           victim_tag,
    output l1_cache_pkg::mesi_t          victim_state
);

    localparam int SETS = 1 << `L1_INDEX_WID;

    l1_cache_pkg::tag_t   tag_mem   [SETS][`L1_WAYS];
    l1_cache_pkg::mesi_t  state_mem [SETS][`L1_WAYS];
    l1_cache_pkg::way_t   ptr_mem   [SETS];
    logic [`L1_WAYS-1:0]  match;

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[lookup_index][tag_way] <= tag_new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                ptr_mem[s] <= '0;
                for (int w = 0; w < `L1_WAYS; w++) begin
                    state_mem[s][w] <= l1_cache_pkg::INVALID;
                end
            end
        end else if (tag_we) begin
            state_mem[lookup_index][tag_way] <= tag_new_state;
            // round robin between the two ways on every fill
            if (tag_fill) begin
                ptr_mem[lookup_index] <= ~ptr_mem[lookup_index];
            end
        end
    end

    // ==============================
    // hit and victim selection
    // ==============================
    always_comb begin
        for (int w = 0; w < `L1_WAYS; w++) begin
            match[w] = (state_mem[lookup_index][w] != l1_cache_pkg::INVALID) &&
                       (tag_mem[lookup_index][w] == lookup_tag);
        end
    end

    assign hit       = |match;
    assign hit_way   = ~match[0];
    assign hit_state = state_mem[lookup_index][hit_way];

    // free way first, lowest one wins
    always_comb begin
        if (state_mem[lookup_index][0] == l1_cache_pkg::INVALID) begin
            victim_way = 1'b0;
        end else if (state_mem[lookup_index][1] == l1_cache_pkg::INVALID) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ptr_mem[lookup_index];
        end
    end

    assign victim_tag   = tag_mem[lookup_index][victim_way];
    assign victim_state = state_mem[lookup_index][victim_way];

endmodule

`default_nettype wire

//--- verification/tb_l1_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_cache_settings.svh"

module tb_l1_dcache;

    localparam int NUM_REQS = 400;
    localparam int TIMEOUT  = 200;
    localparam int WORDS    = 16384;

    logic                   clk;
    logic                   reset;
    logic                   cpu_req_valid;
    logic                   cpu_req_write;
    l1_cache_pkg::addr_t    cpu_req_addr;
    l1_cache_pkg::data_t    cpu_req_wdata;
    logic                   cpu_req_ready;
    logic                   cpu_rsp_valid;
    l1_cache_pkg::data_t    cpu_rsp_rdata;
    logic                   l2_credit_return;
    logic                   l2_rsp_valid;
    l1_cache_pkg::data_t    l2_rsp_data;
    logic                   l2_rsp_shared;
    logic                   l2_req_valid;
    l1_cache_pkg::l2_op_t   l2_req_op;
    l1_cache_pkg::addr_t    l2_req_addr;
    l1_cache_pkg::data_t    l2_req_wdata;

    logic [31:0]            lfsr;

    // level 2 contents, and the latest value of every word
    l1_cache_pkg::data_t    l2_mem [WORDS];
    l1_cache_pkg::data_t    shadow [WORDS];

    // reference cache
    l1_cache_pkg::tag_t     m_tag   [16][2];
    l1_cache_pkg::mesi_t    m_state [16][2];
    logic                   m_ptr   [16];

    // predicted level 2 requests in issue order
    l1_cache_pkg::l2_op_t   exp_op    [$];
    l1_cache_pkg::addr_t    exp_addr  [$];
    l1_cache_pkg::data_t    exp_wdata [$];

    int                     in_use;
    int                     owed;
    int                     credit_wait;
    int                     rsp_wait;
    logic                   rsp_pending;
    l1_cache_pkg::data_t    rsp_data;
    logic                   rsp_shared;
    logic                   last_shared;

    l1_dcache UUT (.*);

    always #2 clk = ~clk;

    // ==============================
    // random bits and checks
    // ==============================
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // 0 to 5 cycles
    function automatic int pick_delay();
        return random_bits(3) % 6;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED at %0d ns: %s = %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    // ==============================
    // level 2 side
    // ==============================
    task automatic take_request();
        l1_cache_pkg::l2_op_t op_e;
        l1_cache_pkg::addr_t  addr_e;
        l1_cache_pkg::data_t  wdata_e;
        if (exp_op.size() == 0) begin
            stop_run($sformatf("level 2 request at %0d ns was not expected", $time));
        end else begin
            op_e    = exp_op.pop_front();
            addr_e  = exp_addr.pop_front();
            wdata_e = exp_wdata.pop_front();
            check_value("l2_req_op", l2_req_op, op_e);
            check_value("l2_req_addr", l2_req_addr, addr_e);
            if (l2_req_op == l1_cache_pkg::L2_WB) begin
                check_value("l2_req_wdata", l2_req_wdata, wdata_e);
                l2_mem[l2_req_addr[15:2]] = l2_req_wdata;
            end else begin
                rsp_pending = 1'b1;
                rsp_wait    = pick_delay();
                rsp_data    = l2_mem[l2_req_addr[15:2]];
                rsp_shared  = lfsr_bit();
                last_shared = rsp_shared;
            end
        end
    endtask

    always @(posedge clk) begin
        l2_credit_return <= 1'b0;
        l2_rsp_valid     <= 1'b0;
        if (!reset) begin
            if (l2_credit_return) begin
                in_use--;
            end
            if (l2_req_valid === 1'b1) begin
                in_use++;
                owed++;
                if (in_use > `L2_CREDITS) begin
                    stop_run("more level 2 requests in flight than credits");
                end
                take_request();
            end
            if (rsp_pending) begin
                if (rsp_wait > 0) begin
                    rsp_wait--;
                end else begin
                    l2_rsp_valid  <= 1'b1;
                    l2_rsp_data   <= rsp_data;
                    l2_rsp_shared <= rsp_shared;
                    rsp_pending    = 1'b0;
                end
            end
            // credits come back late at random
            if (credit_wait > 0) begin
                credit_wait--;
            end else if (owed > 0) begin
                l2_credit_return <= 1'b1;
                owed--;
                credit_wait = pick_delay();
            end
        end
    end

    // ==============================
    // cpu requests against the model
    // ==============================
    task automatic run_request(logic write, l1_cache_pkg::addr_t addr,
                               l1_cache_pkg::data_t wdata);
        l1_cache_pkg::index_t idx;
        l1_cache_pkg::tag_t   tag;
        l1_cache_pkg::addr_t  victim_addr;
        logic                 hit;
        logic                 way;
        int                   cycles;
        idx = addr[5:2];
        tag = addr[15:6];
        hit = 1'b0;
        way = m_ptr[idx];
        for (int w = 0; w < 2; w++) begin
            if (m_state[idx][w] != l1_cache_pkg::INVALID && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit && m_state[idx][0] == l1_cache_pkg::INVALID) begin
            way = 1'b0;
        end else if (!hit && m_state[idx][1] == l1_cache_pkg::INVALID) begin
            way = 1'b1;
        end
        if (!hit) begin
            if (m_state[idx][way] == l1_cache_pkg::MODIFIED) begin
                victim_addr = {m_tag[idx][way], idx, 2'b00};
                exp_op.push_back(l1_cache_pkg::L2_WB);
                exp_addr.push_back(victim_addr);
                exp_wdata.push_back(shadow[victim_addr[15:2]]);
            end
            exp_op.push_back(write ? l1_cache_pkg::L2_RDX : l1_cache_pkg::L2_RD);
            exp_addr.push_back(addr);
            exp_wdata.push_back('0);
        end else if (write && m_state[idx][way] == l1_cache_pkg::SHARED) begin
            exp_op.push_back(l1_cache_pkg::L2_UPGR);
            exp_addr.push_back(addr);
            exp_wdata.push_back('0);
        end

        cpu_req_valid <= 1'b1;
        cpu_req_write <= write;
        cpu_req_addr  <= addr;
        cpu_req_wdata <= wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timed out waiting for the cache to accept a request");
            end
        end while (cpu_req_ready !== 1'b1);
        cpu_req_valid <= 1'b0;

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timed out waiting for the cache response");
            end
        end while (cpu_rsp_valid !== 1'b1);

        if (hit && !(write && m_state[idx][way] == l1_cache_pkg::SHARED)) begin
            check_value("hit latency of cpu_rsp_valid", cycles, 2);
        end
        if (!write) begin
            check_value("cpu_rsp_rdata", cpu_rsp_rdata, shadow[addr[15:2]]);
        end
        if (exp_op.size() != 0) begin
            stop_run("a predicted level 2 request was never sent");
        end

        if (!hit) begin
            m_tag[idx][way] = tag;
            m_ptr[idx]      = ~m_ptr[idx];
            m_state[idx][way] = write ? l1_cache_pkg::MODIFIED
                              : (last_shared ? l1_cache_pkg::SHARED : l1_cache_pkg::EXCLUSIVE);
        end else if (write) begin
            m_state[idx][way] = l1_cache_pkg::MODIFIED;
        end
        if (write) begin
            shadow[addr[15:2]] = wdata;
        end
    endtask

    initial begin
        logic                 write;
        l1_cache_pkg::addr_t  addr;
        l1_cache_pkg::data_t  wdata;
        lfsr             = 32'h8ae3b589;
        clk              = 1'b0;
        reset            = 1'b1;
        cpu_req_valid    = 1'b0;
        cpu_req_write    = 1'b0;
        cpu_req_addr     = '0;
        cpu_req_wdata    = '0;
        l2_credit_return = 1'b0;
        l2_rsp_valid     = 1'b0;
        l2_rsp_data      = '0;
        l2_rsp_shared    = 1'b0;
        in_use           = 0;
        owed             = 0;
        credit_wait      = 0;
        rsp_wait         = 0;
        rsp_pending      = 1'b0;
        last_shared      = 1'b0;
        for (int a = 0; a < WORDS; a++) begin
            l2_mem[a] = 32'(a) * 32'h9e3779b1 + 32'h1357;
            shadow[a] = l2_mem[a];
        end
        for (int s = 0; s < 16; s++) begin
            m_ptr[s]      = 1'b0;
            m_state[s][0] = l1_cache_pkg::INVALID;
            m_state[s][1] = l1_cache_pkg::INVALID;
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("cpu_req_ready", cpu_req_ready, 1);
        check_value("l2_req_valid", l2_req_valid, 0);
        check_value("cpu_rsp_valid", cpu_rsp_valid, 0);

        // few tags over four sets to evict lines often
        for (int n = 0; n < NUM_REQS; n++) begin
            write = lfsr_bit();
            addr  = {7'b0, 3'(random_bits(3)), 2'b00, 2'(random_bits(2)), 2'b00};
            wdata = random_bits(32);
            repeat (random_bits(2)) @(posedge clk);
            run_request(write, addr, wdata);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
